/* tqv_periph_settings.svh */
// Peripheral wrapper constants
// Bus widths, slot map and pin reset selection shared by RTL and testbench

`ifndef TQV_PERIPH_SETTINGS_SVH
`define TQV_PERIPH_SETTINGS_SVH

// Core bus
`define TQV_ADDR_W        11
`define TQV_DATA_W        32

// Slot map, 16 full slots and 16 byte slots
`define TQV_SLOT_CNT      16
`define TQV_SLOT_GPIO     1
`define TQV_SLOT_WORDREGS 2

// Output pins and their function select after reset (GPIO)
`define TQV_PIN_CNT       8
`define TQV_PIN_RESET_SEL 5'd1

`endif

/* tqv_bus_pkg.sv */
// Bus types for the peripheral wrapper
// Core request and the requests fanned out to full and byte slots

`default_nettype none

`include "tqv_periph_settings.svh"

package tqv_bus_pkg;

    // Transfer size code, 11 means idle
    typedef enum logic [1:0] {
        XFER_BYTE = 2'b00,
        XFER_HALF = 2'b01,
        XFER_WORD = 2'b10,
        XFER_NONE = 2'b11
    } xfer_size_t;

    typedef struct packed {
        logic [`TQV_ADDR_W-1:0] addr;
        logic [`TQV_DATA_W-1:0] wdata;
        xfer_size_t             write_n;
        xfer_size_t             read_n;
    } bus_req_t;

    typedef struct packed {
        logic [5:0]             offset;
        logic [`TQV_DATA_W-1:0] wdata;
        xfer_size_t             size;
        logic                   wr;     // write active on the bus
    } full_req_t;

    typedef struct packed {
        logic [3:0] offset;
        logic [7:0] wdata;
        logic       wr;
    } byte_req_t;

endpackage

`default_nettype wire

/* tqv_pin_pkg.sv */
// Pin routing types
// One function select per output pin, naming the slot that drives it

`default_nettype none

`include "tqv_periph_settings.svh"

package tqv_pin_pkg;

    typedef struct packed {
        logic       byte_slot;  // set for byte slots, clear for full slots
        logic [3:0] slot;
    } pin_sel_t;

    typedef pin_sel_t [`TQV_PIN_CNT-1:0] pin_sel_arr_t;

endpackage

`default_nettype wire

/* tqv_bus_ctrl.sv */
// Bus controller for the peripheral wrapper
// Decodes the address into full and byte slots, registers read data
// and holds it until the core reports the read complete

`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_settings.svh"

module tqv_bus_ctrl
    import tqv_bus_pkg::*;
(
    input  wire logic                                       clk,
    input  wire logic                                       rst_n,
    input  wire bus_req_t                                   i_req,
    input  wire logic                                       i_read_complete,
    input  wire logic [`TQV_SLOT_CNT-1:0][`TQV_DATA_W-1:0]  i_full_rdata,
    input  wire logic [`TQV_SLOT_CNT-1:0][7:0]              i_byte_rdata,
    output full_req_t                                       o_full_req,
    output logic [`TQV_SLOT_CNT-1:0]                        o_full_wr_sel,
    output byte_req_t                                       o_byte_req,
    output logic [`TQV_SLOT_CNT-1:0]                        o_byte_wr_sel,
    output logic [`TQV_DATA_W-1:0]                          o_data_out,
    output logic                                            o_data_ready
);

    logic                   byte_space;
    logic [3:0]             full_slot;
    logic [3:0]             byte_slot;
    logic                   write_act;
    logic                   read_act;
    logic                   read_sample;
    logic                   ready_r;
    logic                   hold;
    logic [`TQV_DATA_W-1:0] slot_rdata;

    assign byte_space = i_req.addr[`TQV_ADDR_W-1];
    assign full_slot  = i_req.addr[9:6];
    assign byte_slot  = i_req.addr[7:4];
    assign write_act  = (i_req.write_n != XFER_NONE);
    assign read_act   = (i_req.read_n != XFER_NONE);

    // A held read is not sampled again once ready is up
    assign read_sample = read_act && !ready_r;

    // Shared requests, only the strobe vectors are per slot
    assign o_full_req = '{offset: i_req.addr[5:0], wdata: i_req.wdata,
                          size: i_req.write_n, wr: write_act};
    assign o_byte_req = '{offset: i_req.addr[3:0], wdata: i_req.wdata[7:0],
                          wr: write_act};

    always_comb begin
        o_full_wr_sel = '0;
        o_byte_wr_sel = '0;
        if (write_act) begin
            if (byte_space) begin
                o_byte_wr_sel[byte_slot] = 1'b1;
            end else begin
                o_full_wr_sel[full_slot] = 1'b1;
            end
        end
    end

    assign slot_rdata = byte_space ? {24'h0, i_byte_rdata[byte_slot]} : i_full_rdata[full_slot];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (read_sample && !hold) begin
                hold <= 1'b1;
            end
            // Every populated slot answers at once, so ready follows the read
            ready_r <= read_act;
        end
    end

    // Captured read data, stable while the hold flag is set
    always_ff @(posedge clk) begin
        if (read_sample && !hold) begin
            o_data_out <= slot_rdata;
        end
    end

    // Writes complete in the cycle they are presented
    assign o_data_ready = ready_r || write_act;

endmodule

`default_nettype wire

/* tqv_gpio.sv */
// GPIO block in full slot 1
// Output register, input pin readback and per-pin output function selects

`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_settings.svh"

module tqv_gpio
    import tqv_bus_pkg::*;
    import tqv_pin_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire full_req_t              i_req,
    input  wire logic                   i_wr,
    input  wire logic [7:0]             i_ui_in,
    output logic [`TQV_DATA_W-1:0]      o_rdata,
    output logic [`TQV_PIN_CNT-1:0]     o_gpio_out,
    output pin_sel_arr_t                o_pin_sel
);

    logic       wr_en;
    logic       sel_hit;
    logic [2:0] sel_idx;

    assign wr_en   = i_wr && i_req.wr;

    // Pin selects live at 0x20..0x3C, one word each
    assign sel_hit = i_req.offset[5] && (i_req.offset[1:0] == 2'b00);
    assign sel_idx = i_req.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_gpio_out <= '0;
            for (int i = 0; i < `TQV_PIN_CNT; i++) begin
                o_pin_sel[i] <= pin_sel_t'(`TQV_PIN_RESET_SEL);
            end
        end else if (wr_en) begin
            if (i_req.offset == 6'h00) begin
                o_gpio_out <= i_req.wdata[7:0];
            end
            if (sel_hit) begin
                o_pin_sel[sel_idx] <= pin_sel_t'(i_req.wdata[4:0]);
            end
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_req.offset == 6'h00) begin
            o_rdata[7:0] = o_gpio_out;
        end else if (i_req.offset == 6'h04) begin
            o_rdata[7:0] = i_ui_in;
        end else if (sel_hit) begin
            o_rdata[4:0] = o_pin_sel[sel_idx];
        end
    end

endmodule

`default_nettype wire

/* tqv_pin_mux.sv */
// Output pin routing
// Each pin takes its own bit from the pin byte of the slot it selects

`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_settings.svh"

module tqv_pin_mux
    import tqv_pin_pkg::*;
(
    input  wire pin_sel_arr_t                               i_pin_sel,
    input  wire logic [`TQV_SLOT_CNT-1:0][`TQV_PIN_CNT-1:0] i_full_pins,
    input  wire logic [`TQV_SLOT_CNT-1:0][`TQV_PIN_CNT-1:0] i_byte_pins,
    output logic [`TQV_PIN_CNT-1:0]                         o_uo_out
);

    genvar n;
    generate
        for (n = 0; n < `TQV_PIN_CNT; n++) begin : g_pin
            pin_sel_t sel;
            logic [`TQV_PIN_CNT-1:0] full_byte;
            logic [`TQV_PIN_CNT-1:0] slot_byte;

            assign sel       = i_pin_sel[n];
            assign full_byte = i_full_pins[sel.slot];
            assign slot_byte = i_byte_pins[sel.slot];

            // Byte slot flag picks which space the slot number refers to
            assign o_uo_out[n] = sel.byte_slot ? slot_byte[n] : full_byte[n];
        end
    endgenerate

endmodule

`default_nettype wire

/* tqv_word_regs.sv */
// Full-slot register peripheral
// Four 32-bit registers taking byte, halfword and word writes,
// low byte of register 0 drives the pin byte

`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_settings.svh"

module tqv_word_regs
    import tqv_bus_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire full_req_t              i_req,
    input  wire logic                   i_wr,
    output logic [`TQV_DATA_W-1:0]      o_rdata,
    output logic [`TQV_PIN_CNT-1:0]     o_pins
);

    logic [3:0][`TQV_DATA_W-1:0] regs;
    logic                        hit;
    logic [1:0]                  idx;

    // Registers at 0x0, 0x4, 0x8 and 0xC
    assign hit = (i_req.offset[5:4] == 2'b00) && (i_req.offset[1:0] == 2'b00);
    assign idx = i_req.offset[3:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (i_wr && i_req.wr && hit) begin
            case (i_req.size)
                XFER_BYTE: regs[idx][7:0]  <= i_req.wdata[7:0];
                XFER_HALF: regs[idx][15:0] <= i_req.wdata[15:0];
                XFER_WORD: regs[idx]       <= i_req.wdata;
                default:   regs[idx]       <= regs[idx];
            endcase
        end
    end

    assign o_rdata = hit ? regs[idx] : '0;
    assign o_pins  = regs[0][`TQV_PIN_CNT-1:0];

endmodule

`default_nettype wire

/* tqv_byte_regs.sv */
// Byte-slot register peripheral
// Four 8-bit registers at offsets 0 to 3, register 0 drives the pins

`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_settings.svh"

module tqv_byte_regs
    import tqv_bus_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire byte_req_t              i_req,
    input  wire logic                   i_wr,
    output logic [7:0]                  o_rdata,
    output logic [`TQV_PIN_CNT-1:0]     o_pins
);

    logic [3:0][7:0] regs;
    logic            hit;

    assign hit = (i_req.offset[3:2] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (i_wr && i_req.wr && hit) begin
            regs[i_req.offset[1:0]] <= i_req.wdata;
        end
    end

    assign o_rdata = hit ? regs[i_req.offset[1:0]] : 8'h00;
    assign o_pins  = regs[0];

endmodule

`default_nettype wire

/* tqv_periph_top.sv */
// Peripheral wrapper top level
// Bus controller, GPIO, one full-slot register block in slot 2,
// byte register blocks in byte slots 0 and 1, and the pin router

`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_settings.svh"

module tqv_periph_top
    import tqv_bus_pkg::*;
    import tqv_pin_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [7:0]                 i_ui_in,
    output logic [`TQV_PIN_CNT-1:0]         o_uo_out,
    input  wire logic [`TQV_ADDR_W-1:0]     i_addr,
    input  wire logic [`TQV_DATA_W-1:0]     i_data,
    input  wire xfer_size_t                 i_data_write_n,
    input  wire xfer_size_t                 i_data_read_n,
    output logic [`TQV_DATA_W-1:0]          o_data_out,
    output logic                            o_data_ready,
    input  wire logic                       i_data_read_complete
);

    bus_req_t                                   bus_req;
    full_req_t                                  full_req;
    byte_req_t                                  byte_req;
    logic [`TQV_SLOT_CNT-1:0]                   full_wr_sel;
    logic [`TQV_SLOT_CNT-1:0]                   byte_wr_sel;
    logic [`TQV_SLOT_CNT-1:0][`TQV_DATA_W-1:0]  full_rdata;
    logic [`TQV_SLOT_CNT-1:0][7:0]              byte_rdata;
    logic [`TQV_SLOT_CNT-1:0][`TQV_PIN_CNT-1:0] full_pins;
    logic [`TQV_SLOT_CNT-1:0][`TQV_PIN_CNT-1:0] byte_pins;
    pin_sel_arr_t                               pin_sel;
    logic [`TQV_DATA_W-1:0]                     gpio_rdata;
    logic [`TQV_PIN_CNT-1:0]                    gpio_pins;
    logic [`TQV_DATA_W-1:0]                     word_rdata;
    logic [`TQV_PIN_CNT-1:0]                    word_pins;
    logic [1:0][7:0]                            breg_rdata;
    logic [1:0][`TQV_PIN_CNT-1:0]               breg_pins;

    assign bus_req = '{addr: i_addr, wdata: i_data,
                       write_n: i_data_write_n, read_n: i_data_read_n};

    tqv_bus_ctrl u_bus_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (bus_req),
        .i_read_complete (i_data_read_complete),
        .i_full_rdata    (full_rdata),
        .i_byte_rdata    (byte_rdata),
        .o_full_req      (full_req),
        .o_full_wr_sel   (full_wr_sel),
        .o_byte_req      (byte_req),
        .o_byte_wr_sel   (byte_wr_sel),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready)
    );

    tqv_gpio u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (full_req),
        .i_wr       (full_wr_sel[`TQV_SLOT_GPIO]),
        .i_ui_in    (i_ui_in),
        .o_rdata    (gpio_rdata),
        .o_gpio_out (gpio_pins),
        .o_pin_sel  (pin_sel)
    );

    tqv_word_regs u_word_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_req   (full_req),
        .i_wr    (full_wr_sel[`TQV_SLOT_WORDREGS]),
        .o_rdata (word_rdata),
        .o_pins  (word_pins)
    );

    // Byte slots 0 and 1
    genvar b;
    generate
        for (b = 0; b < 2; b++) begin : g_byte_regs
            tqv_byte_regs u_byte_regs (
                .clk     (clk),
                .rst_n   (rst_n),
                .i_req   (byte_req),
                .i_wr    (byte_wr_sel[b]),
                .o_rdata (breg_rdata[b]),
                .o_pins  (breg_pins[b])
            );
        end
    endgenerate

    // Unpopulated slots read zero and drive no pins
    always_comb begin
        full_rdata = '0;
        full_pins  = '0;
        byte_rdata = '0;
        byte_pins  = '0;
        full_rdata[`TQV_SLOT_GPIO]     = gpio_rdata;
        full_pins[`TQV_SLOT_GPIO]      = gpio_pins;
        full_rdata[`TQV_SLOT_WORDREGS] = word_rdata;
        full_pins[`TQV_SLOT_WORDREGS]  = word_pins;
        byte_rdata[1:0]                = breg_rdata;
        byte_pins[1:0]                 = breg_pins;
    end

    tqv_pin_mux u_pin_mux (
        .i_pin_sel   (pin_sel),
        .i_full_pins (full_pins),
        .i_byte_pins (byte_pins),
        .o_uo_out    (o_uo_out)
    );

endmodule

`default_nettype wire

/* tqv_periph_assertions.sv */
// Bus controller checks
// Read ready timing, held read data and write ready

`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_settings.svh"

module tqv_periph_assertions (
    input wire logic                   clk,
    input wire logic                   rst_n,
    input wire logic                   i_read_act,
    input wire logic                   i_read_sample,
    input wire logic                   i_ready_r,
    input wire logic                   i_hold,
    input wire logic                   i_read_complete,
    input wire logic                   i_write_act,
    input wire logic                   i_data_ready,
    input wire logic [`TQV_DATA_W-1:0] i_slot_rdata,
    input wire logic [`TQV_DATA_W-1:0] i_data_out
);

    int fail_cnt = 0;

    // A sampled read raises ready at the next edge with the slot data captured
    a_read_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        i_read_sample |=> (i_ready_r && (i_data_out == $past(i_slot_rdata)))
    ) else begin
        $error("read ready did not follow a sampled read");
        fail_cnt++;
    end

    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (i_hold && !i_read_complete) |=> $stable(i_data_out)
    ) else begin
        $error("read data changed while held");
        fail_cnt++;
    end

    // Without a read in the previous cycle ready is exactly the write strobe
    a_write_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$past(i_read_act) |-> (i_data_ready == i_write_act)
    ) else begin
        $error("write ready does not match the active write");
        fail_cnt++;
    end

endmodule

bind tqv_bus_ctrl tqv_periph_assertions u_bus_checks (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_read_act      (read_act),
    .i_read_sample   (read_sample),
    .i_ready_r       (ready_r),
    .i_hold          (hold),
    .i_read_complete (i_read_complete),
    .i_write_act     (write_act),
    .i_data_ready    (o_data_ready),
    .i_slot_rdata    (slot_rdata),
    .i_data_out      (o_data_out)
);

`default_nettype wire

/* tqv_periph_tb.sv */
// Testbench for the peripheral wrapper
// Directed tests over reset state, GPIO, sized register writes, byte slots,
// pin routing, read hold and unpopulated slots

`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_settings.svh"

module tqv_periph_tb
    import tqv_bus_pkg::*;
();

    // About 30 bus transfers of 3 to 5 cycles each fit well under this limit
    localparam int CYCLE_LIMIT = 2000;
    localparam int READY_WAIT  = 8;

    localparam logic [`TQV_ADDR_W-1:0] GPIO_BASE   = `TQV_SLOT_GPIO * 64;
    localparam logic [`TQV_ADDR_W-1:0] PINSEL_BASE = GPIO_BASE + 11'h20;
    localparam logic [`TQV_ADDR_W-1:0] WORD_BASE   = `TQV_SLOT_WORDREGS * 64;
    localparam logic [`TQV_ADDR_W-1:0] BYTE0_BASE  = 11'h400;
    localparam logic [`TQV_ADDR_W-1:0] BYTE1_BASE  = 11'h410;

    logic                   clk;
    logic                   rst_n;
    logic [7:0]             ui_in;
    logic [7:0]             uo_out;
    logic [`TQV_ADDR_W-1:0] addr;
    logic [`TQV_DATA_W-1:0] data;
    xfer_size_t             write_n;
    xfer_size_t             read_n;
    logic [`TQV_DATA_W-1:0] data_out;
    logic                   data_ready;
    logic                   read_complete;

    int          err_total;
    int          test_errs;
    int          tests_run;
    int          tests_failed;
    int          assert_fails;
    int unsigned cycle_cnt = 0;
    logic [7:0]  gpio_val;

    tqv_periph_top UUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .o_uo_out             (uo_out),
        .i_addr               (addr),
        .i_data               (data),
        .i_data_write_n       (write_n),
        .i_data_read_n        (read_n),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .i_data_read_complete (read_complete)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED %s: %s expected 0x%08h actual 0x%08h", test, what, exp, act);
        test_errs++;
        err_total++;
    endtask

    task automatic report_error(input string test, input string msg);
        $display("ERROR in %s: %s", test, msg);
        test_errs++;
        err_total++;
    endtask

    task automatic finish_test(input string test);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %-14s ok", test);
        end else begin
            $display("test %-14s %0d errors", test, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // Write ready is expected in the same cycle and the register updates at the next edge
    task automatic write_bus(input string test, input logic [10:0] a,
                             input logic [31:0] d, input xfer_size_t size);
        @(posedge clk);
        addr    <= a;
        data    <= d;
        write_n <= size;
        @(negedge clk);
        if (!data_ready) begin
            report_error(test, $sformatf("no write ready at address 0x%03h", a));
        end
        @(posedge clk);
        write_n <= XFER_NONE;
    endtask

    task automatic start_read(input logic [10:0] a, input xfer_size_t size);
        @(posedge clk);
        addr   <= a;
        read_n <= size;
    endtask

    // Ready is due one cycle after the read is first sampled
    task automatic wait_ready(input string test, output bit ok);
        int waited;
        waited = 0;
        ok     = 1'b0;
        while (!ok && waited < READY_WAIT) begin
            @(negedge clk);
            ok = data_ready;
            waited++;
        end
        if (!ok) begin
            report_error(test, "read ready never came");
        end else if (waited != 2) begin
            report_mismatch(test, "read ready latency", 32'd2, waited);
        end
    endtask

    task automatic finish_read();
        @(posedge clk);
        read_n        <= XFER_NONE;
        read_complete <= 1'b1;
        @(posedge clk);
        read_complete <= 1'b0;
    endtask

    task automatic read_bus(input string test, input logic [10:0] a,
                            input xfer_size_t size, output logic [31:0] d);
        bit ok;
        start_read(a, size);
        wait_ready(test, ok);
        d = data_out;
        finish_read();
    endtask

    task automatic test_reset_state();
        logic [31:0] rd;
        @(negedge clk);
        if (uo_out !== 8'h00) report_mismatch("reset_state", "uo_out", 32'h0, uo_out);
        read_bus("reset_state", GPIO_BASE, XFER_WORD, rd);
        if (rd !== 32'h0) report_mismatch("reset_state", "gpio out", 32'h0, rd);
        // Every pin starts on full slot 1 which holds the GPIO block
        for (int n = 0; n < `TQV_PIN_CNT; n++) begin
            read_bus("reset_state", PINSEL_BASE + 11'(4 * n), XFER_WORD, rd);
            if (rd !== 32'h1) begin
                report_mismatch("reset_state", $sformatf("pin %0d select", n), 32'h1, rd);
            end
        end
        finish_test("reset_state");
    endtask

    task automatic test_gpio();
        logic [31:0] rd;
        logic [7:0]  ui;
        gpio_val = 8'($urandom);
        write_bus("gpio", GPIO_BASE, {24'($urandom), gpio_val}, XFER_WORD);
        read_bus("gpio", GPIO_BASE, XFER_WORD, rd);
        if (rd !== {24'h0, gpio_val}) report_mismatch("gpio", "out readback", gpio_val, rd);
        @(negedge clk);
        if (uo_out !== gpio_val) report_mismatch("gpio", "uo_out", gpio_val, uo_out);
        ui = 8'($urandom);
        @(posedge clk);
        ui_in <= ui;
        read_bus("gpio", GPIO_BASE + 11'h04, XFER_WORD, rd);
        if (rd !== {24'h0, ui}) report_mismatch("gpio", "input readback", ui, rd);
        finish_test("gpio");
    endtask

    task automatic test_sized_writes();
        logic [31:0] exp;
        logic [31:0] wd;
        logic [31:0] rd;
        exp = $urandom;
        write_bus("sized_writes", WORD_BASE + 11'h04, exp, XFER_WORD);
        read_bus("sized_writes", WORD_BASE + 11'h04, XFER_WORD, rd);
        if (rd !== exp) report_mismatch("sized_writes", "word write", exp, rd);
        wd = $urandom;
        exp[15:0] = wd[15:0];
        write_bus("sized_writes", WORD_BASE + 11'h04, wd, XFER_HALF);
        read_bus("sized_writes", WORD_BASE + 11'h04, XFER_WORD, rd);
        if (rd !== exp) report_mismatch("sized_writes", "halfword write", exp, rd);
        wd = $urandom;
        exp[7:0] = wd[7:0];
        write_bus("sized_writes", WORD_BASE + 11'h04, wd, XFER_BYTE);
        read_bus("sized_writes", WORD_BASE + 11'h04, XFER_WORD, rd);
        if (rd !== exp) report_mismatch("sized_writes", "byte write", exp, rd);
        finish_test("sized_writes");
    endtask

    task automatic test_byte_slots();
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [7:0]  exp_pins;
        logic [31:0] rd;
        b0 = 8'($urandom);
        b1 = 8'($urandom);
        // Pin 3 differs between GPIO and byte slot 1 so the routing shows
        b1[3] = ~gpio_val[3];
        if (b0 == b1) begin
            b0 = ~b1;
        end
        write_bus("byte_slots", BYTE0_BASE, {24'($urandom), b0}, XFER_BYTE);
        write_bus("byte_slots", BYTE1_BASE, {24'($urandom), b1}, XFER_BYTE);
        read_bus("byte_slots", BYTE0_BASE, XFER_BYTE, rd);
        if (rd !== {24'h0, b0}) report_mismatch("byte_slots", "byte slot 0", b0, rd);
        read_bus("byte_slots", BYTE1_BASE, XFER_BYTE, rd);
        if (rd !== {24'h0, b1}) report_mismatch("byte_slots", "byte slot 1", b1, rd);
        // Byte-slot flag in bit 4 and slot number 1
        write_bus("byte_slots", PINSEL_BASE + 11'h0C, 32'h11, XFER_WORD);
        read_bus("byte_slots", PINSEL_BASE + 11'h0C, XFER_WORD, rd);
        if (rd !== 32'h11) report_mismatch("byte_slots", "pin 3 select", 32'h11, rd);
        exp_pins    = gpio_val;
        exp_pins[3] = b1[3];
        @(negedge clk);
        if (uo_out !== exp_pins) report_mismatch("byte_slots", "uo_out", exp_pins, uo_out);
        finish_test("byte_slots");
    endtask

    task automatic test_read_hold();
        logic [7:0]  v;
        logic [31:0] held;
        logic [31:0] rd;
        bit          ok;
        v = 8'($urandom);
        @(posedge clk);
        ui_in <= v;
        start_read(GPIO_BASE + 11'h04, XFER_WORD);
        wait_ready("read_hold", ok);
        held = data_out;
        if (held !== {24'h0, v}) report_mismatch("read_hold", "captured", v, held);
        repeat (6) begin
            @(posedge clk);
            ui_in <= v ^ (8'($urandom) | 8'h01);
            @(negedge clk);
            if (data_out !== held) report_mismatch("read_hold", "held data", held, data_out);
            if (!data_ready) report_error("read_hold", "ready dropped while the read was held");
        end
        finish_read();
        // A fresh read picks up the current pins
        read_bus("read_hold", GPIO_BASE + 11'h04, XFER_WORD, rd);
        if (rd !== {24'h0, ui_in}) report_mismatch("read_hold", "next read", ui_in, rd);
        finish_test("read_hold");
    endtask

    task automatic test_unpopulated();
        logic [31:0] rd;
        read_bus("unpopulated", 11'h1C0, XFER_WORD, rd);
        if (rd !== 32'h0) report_mismatch("unpopulated", "full slot 7", 32'h0, rd);
        read_bus("unpopulated", 11'h490, XFER_BYTE, rd);
        if (rd !== 32'h0) report_mismatch("unpopulated", "byte slot 9", 32'h0, rd);
        finish_test("unpopulated");
    endtask

    initial begin
        void'($urandom(88));
        rst_n         = 1'b0;
        ui_in         = 8'h00;
        addr          = '0;
        data          = '0;
        write_n       = XFER_NONE;
        read_n        = XFER_NONE;
        read_complete = 1'b0;
        err_total     = 0;
        test_errs     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        gpio_val      = 8'h00;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_state();
        test_gpio();
        test_sized_writes();
        test_byte_slots();
        test_read_hold();
        test_unpopulated();

        assert_fails = UUT.u_bus_ctrl.u_bus_checks.fail_cnt;
        $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, err_total, assert_fails);
        if (err_total == 0 && assert_fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tqv_periph.f */
+incdir+.
tqv_bus_pkg.sv
tqv_pin_pkg.sv
tqv_bus_ctrl.sv
tqv_gpio.sv
tqv_pin_mux.sv
tqv_word_regs.sv
tqv_byte_regs.sv
tqv_periph_top.sv
tqv_periph_assertions.sv
tqv_periph_tb.sv
